/* lock_pkg.sv */
package lock_pkg;

    // keypad event kinds
    typedef enum logic [2:0] {
        KEY_NONE  = 3'd0,
        KEY_DIGIT = 3'd1,
        KEY_BACK  = 3'd2,
        KEY_ENTER = 3'd3,
        KEY_SET   = 3'd4,
        KEY_CLEAR = 3'd5
    } key_kind_t;

    // one decoded keypress, valid for a single cycle
    typedef struct packed {
        logic      valid;
        key_kind_t kind;
        logic [3:0] digit;  // bcd, only meaningful for KEY_DIGIT
    } key_evt_t;

    // digit buffer as seen by the controller
    typedef struct packed {
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] units;
        logic [1:0] count;  // digits typed, 0 to 3
    } entry_t;

    // tone channels, higher value wins the buzzer
    typedef enum logic [1:0] {
        TONE_CLICK   = 2'd0,
        TONE_SUCCESS = 2'd1,
        TONE_FAIL    = 2'd2
    } tone_t;

    localparam int NUM_TONES = 3;

    // display nibble codes
    localparam logic [3:0]  NIB_BLANK       = 4'hF;
    localparam logic [3:0]  NIB_SET         = 4'hD;
    localparam logic [11:0] DISP_PASS       = 12'hBCC;
    localparam logic [11:0] DISP_LOCK_START = 12'h020;  // 20 s lockout, bcd

    localparam logic [11:0] DEFAULT_CODE = 12'h246;

    // empty buffer, all digits dark
    localparam entry_t ENTRY_EMPTY = '{
        hundreds: NIB_BLANK,
        tens:     NIB_BLANK,
        units:    NIB_BLANK,
        count:    2'd0
    };

endpackage

/* key_decoder.sv */
`timescale 1ns/1ps

module key_decoder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [15:0]        keys,
    output lock_pkg::key_evt_t key_evt
);
    import lock_pkg::*;

    key_kind_t  dec_kind;
    logic [3:0] dec_digit;
    key_kind_t  cur_kind;
    logic [3:0] cur_digit;
    key_kind_t  prev_kind;
    logic [3:0] prev_digit;
    logic       key_changed;

    // anything not one-hot decodes as none
    always_comb begin
        case (keys)
            16'h0008: dec_digit = 4'd0;
            16'h0080: dec_digit = 4'd1;
            16'h0040: dec_digit = 4'd2;
            16'h0020: dec_digit = 4'd3;
            16'h0800: dec_digit = 4'd4;
            16'h0400: dec_digit = 4'd5;
            16'h0200: dec_digit = 4'd6;
            16'h8000: dec_digit = 4'd7;
            16'h4000: dec_digit = 4'd8;  // old debug slot
            16'h2000: dec_digit = 4'd9;
            default:  dec_digit = NIB_BLANK;
        endcase
        case (keys)
            16'h0001: dec_kind = KEY_ENTER;
            16'h0010: dec_kind = KEY_SET;
            16'h0100: dec_kind = KEY_CLEAR;
            16'h1000: dec_kind = KEY_BACK;
            default:  dec_kind = (dec_digit != NIB_BLANK) ? KEY_DIGIT : KEY_NONE;
        endcase
    end

    assign key_changed = {cur_kind, cur_digit} != {prev_kind, prev_digit};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_kind   <= KEY_NONE;
            cur_digit  <= NIB_BLANK;
            prev_kind  <= KEY_NONE;
            prev_digit <= NIB_BLANK;
            key_evt    <= '0;
        end else begin
            cur_kind      <= dec_kind;  // sample stage
            cur_digit     <= dec_digit;
            prev_kind     <= cur_kind;
            prev_digit    <= cur_digit;
            key_evt.valid <= key_changed && (cur_kind != KEY_NONE);  // release is silent
            key_evt.kind  <= cur_kind;
            key_evt.digit <= cur_digit;
        end
    end

endmodule

/* digit_entry.sv */
`timescale 1ns/1ps

module digit_entry (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [3:0]       push_digit,
    input  logic             pop,
    input  logic             flush,
    output lock_pkg::entry_t entry
);
    import lock_pkg::*;

    entry_t entry_nxt;
    logic   can_push;
    logic   can_pop;

    assign can_push = entry.count < 2'd3;  // fourth digit is dropped
    assign can_pop  = entry.count != 2'd0;

    always_comb begin
        entry_nxt = entry;
        if (flush) begin
            entry_nxt = ENTRY_EMPTY;
        end else if (push && can_push) begin
            // shift left, new digit lands in units
            entry_nxt.hundreds = entry.tens;
            entry_nxt.tens     = entry.units;
            entry_nxt.units    = push_digit;
            entry_nxt.count    = entry.count + 2'd1;
        end else if (pop && can_pop) begin
            // shift right, blank comes in from the top
            entry_nxt.units    = entry.tens;
            entry_nxt.tens     = entry.hundreds;
            entry_nxt.hundreds = NIB_BLANK;
            entry_nxt.count    = entry.count - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry <= ENTRY_EMPTY;
        end else begin
            entry <= entry_nxt;
        end
    end

endmodule

/* lock_fsm.sv */
`timescale 1ns/1ps

module lock_fsm #(
    parameter int unsigned TICK_DIV  = 50_000_000,
    parameter int unsigned MAX_FAILS = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  lock_pkg::key_evt_t              key_evt,
    input  lock_pkg::entry_t                entry,
    output logic                            push,
    output logic [3:0]                      push_digit,
    output logic                            pop,
    output logic                            flush,
    output logic [lock_pkg::NUM_TONES-1:0]  tone_start,
    output logic [11:0]                     display,
    output logic [3:0]                      tries
);
    import lock_pkg::*;

    localparam int TICK_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,    // normal entry
        ST_SET,     // next full entry becomes the code
        ST_PASSED,
        ST_LOCKED,  // countdown running
        ST_DEAD     // countdown at 000, waiting for clear
    } state_t;

    state_t            state;
    logic [11:0]       code;
    logic [11:0]       countdown;
    logic [11:0]       count_dec;
    logic [TICK_W-1:0] tick_cnt;
    logic [11:0]       entry_code;
    logic [3:0]        tries_inc;
    logic              in_entry;
    logic              entry_full;
    logic              accepted;

    // three digit bcd decrement, caller keeps v above zero
    function automatic logic [11:0] bcd_dec(input logic [11:0] v);
        logic [11:0] r;
        r = v;
        if (r[3:0] != 4'd0) begin
            r[3:0] = r[3:0] - 4'd1;
        end else begin
            r[3:0] = 4'd9;
            if (r[7:4] != 4'd0) begin
                r[7:4] = r[7:4] - 4'd1;
            end else begin
                r[7:4]  = 4'd9;
                r[11:8] = r[11:8] - 4'd1;
            end
        end
        return r;
    endfunction

    assign entry_code = {entry.hundreds, entry.tens, entry.units};
    assign entry_full = entry.count == 2'd3;
    assign in_entry   = (state == ST_IDLE) || (state == ST_SET);
    assign tries_inc  = tries + 4'd1;
    assign count_dec  = bcd_dec(countdown);

    // partial enter is ignored, passed and dead only take clear
    assign accepted = key_evt.valid &&
                      (in_entry ? (key_evt.kind != KEY_ENTER || entry_full)
                                : (state != ST_LOCKED && key_evt.kind == KEY_CLEAR));

    // buffer commands go out in the event cycle
    assign push       = accepted && key_evt.kind == KEY_DIGIT;
    assign push_digit = key_evt.digit;
    assign pop        = accepted && key_evt.kind == KEY_BACK;
    assign flush      = accepted && (key_evt.kind == KEY_ENTER || key_evt.kind == KEY_SET ||
                                     key_evt.kind == KEY_CLEAR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            code       <= DEFAULT_CODE;
            countdown  <= '0;
            tick_cnt   <= '0;
            tries      <= 4'd0;
            tone_start <= '0;
        end else begin
            tone_start <= '0;
            if (accepted) begin
                tone_start[TONE_CLICK] <= 1'b1;  // every accepted key clicks
                case (key_evt.kind)
                    KEY_CLEAR: begin
                        state <= ST_IDLE;
                        tries <= 4'd0;
                    end
                    KEY_SET: state <= ST_SET;
                    KEY_ENTER: begin
                        if (state == ST_SET) begin
                            code                     <= entry_code;
                            tries                    <= 4'd0;
                            state                    <= ST_IDLE;
                            tone_start[TONE_SUCCESS] <= 1'b1;
                        end else if (entry_code == code) begin
                            state                    <= ST_PASSED;
                            tone_start[TONE_SUCCESS] <= 1'b1;
                        end else begin
                            tone_start[TONE_FAIL] <= 1'b1;
                            if (tries_inc == 4'(MAX_FAILS)) begin
                                tries     <= 4'd0;
                                state     <= ST_LOCKED;
                                countdown <= DISP_LOCK_START;
                                tick_cnt  <= '0;
                            end else begin
                                tries <= tries_inc;
                            end
                        end
                    end
                    default: ;  // digit and back handled by the buffer
                endcase
            end else if (state == ST_LOCKED) begin
                if (tick_cnt == TICK_W'(TICK_DIV - 1)) begin
                    tick_cnt  <= '0;
                    countdown <= count_dec;
                    if (count_dec == 12'h000) begin
                        state <= ST_DEAD;
                    end
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (state)
            ST_IDLE:   display = entry_code;
            ST_SET:    display = (entry.count == 2'd0) ? {3{NIB_SET}} : entry_code;
            ST_PASSED: display = DISP_PASS;
            default:   display = countdown;  // locked and dead
        endcase
    end

endmodule

/* tone_gen.sv */
`timescale 1ns/1ps

module tone_gen #(
    parameter int unsigned HALF = 4,   // cycles per half period
    parameter int unsigned LEN  = 64   // tone length in cycles
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic cancel,
    output logic active,
    output logic wave
);

    logic [31:0] dur_cnt;
    logic [31:0] half_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            wave     <= 1'b0;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (start) begin
            active   <= 1'b1;  // also restarts a running tone
            wave     <= 1'b1;
            dur_cnt  <= '0;
            half_cnt <= '0;
        end else if (active) begin
            if (cancel || dur_cnt == LEN - 1) begin
                active <= 1'b0;
                wave   <= 1'b0;
            end else begin
                dur_cnt <= dur_cnt + 32'd1;
                if (half_cnt == HALF - 1) begin
                    half_cnt <= '0;
                    wave     <= ~wave;
                end else begin
                    half_cnt <= half_cnt + 32'd1;
                end
            end
        end
    end

endmodule

/* buzzer_arbiter.sv */
`timescale 1ns/1ps

module buzzer_arbiter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [lock_pkg::NUM_TONES-1:0] active,
    input  logic [lock_pkg::NUM_TONES-1:0] wave,
    output logic [lock_pkg::NUM_TONES-1:0] cancel,
    output logic                           buzzer
);
    import lock_pkg::*;

    tone_t sel_idx;
    logic  sel_valid;

    // walk down from fail, first active channel owns the pin
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = TONE_CLICK;
        cancel    = '0;
        for (int i = NUM_TONES - 1; i >= 0; i--) begin
            if (active[i]) begin
                if (sel_valid) begin
                    cancel[i] = 1'b1;  // lower tone cut off
                end else begin
                    sel_valid = 1'b1;
                    sel_idx   = tone_t'(i);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buzzer <= 1'b0;
        end else begin
            buzzer <= sel_valid ? wave[sel_idx] : 1'b0;
        end
    end

endmodule

/* code_lock_top.sv */
`timescale 1ns/1ps

module code_lock_top #(
    parameter int unsigned TICK_DIV  = 50_000_000,  // one second at 50 MHz
    parameter int unsigned MAX_FAILS = 4,
    // index order fail, success, click
    parameter logic [lock_pkg::NUM_TONES-1:0][31:0] TONE_HALF =
        {32'd100_000, 32'd25_000, 32'd50_000},
    parameter logic [lock_pkg::NUM_TONES-1:0][31:0] TONE_LEN =
        {32'd15_000_000, 32'd30_000_000, 32'd10_000_000}
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] keys,      // one-hot keypad level
    output logic [11:0] display,
    output logic [3:0]  tries,
    output logic        buzzer
);
    import lock_pkg::*;

    key_evt_t             key_evt;
    entry_t               entry;
    logic                 push;
    logic [3:0]           push_digit;
    logic                 pop;
    logic                 flush;
    logic [NUM_TONES-1:0] tone_start;
    logic [NUM_TONES-1:0] tone_active;
    logic [NUM_TONES-1:0] tone_wave;
    logic [NUM_TONES-1:0] tone_cancel;

    key_decoder key_decoder_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .keys    (keys),
        .key_evt (key_evt)
    );

    digit_entry digit_entry_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_digit (push_digit),
        .pop        (pop),
        .flush      (flush),
        .entry      (entry)
    );

    lock_fsm #(
        .TICK_DIV  (TICK_DIV),
        .MAX_FAILS (MAX_FAILS)
    ) lock_fsm_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_evt    (key_evt),
        .entry      (entry),
        .push       (push),
        .push_digit (push_digit),
        .pop        (pop),
        .flush      (flush),
        .tone_start (tone_start),
        .display    (display),
        .tries      (tries)
    );

    // one generator per channel, indexed by tone_t
    for (genvar g = 0; g < NUM_TONES; g++) begin : g_tone
        tone_gen #(
            .HALF (TONE_HALF[g]),
            .LEN  (TONE_LEN[g])
        ) tone_gen_i (
            .clk    (clk),
            .rst_n  (rst_n),
            .start  (tone_start[g]),
            .cancel (tone_cancel[g]),
            .active (tone_active[g]),
            .wave   (tone_wave[g])
        );
    end

    buzzer_arbiter buzzer_arbiter_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .active (tone_active),
        .wave   (tone_wave),
        .cancel (tone_cancel),
        .buzzer (buzzer)
    );

endmodule

/* tb_code_lock.sv */
`timescale 1ns/1ps

module tb_code_lock;
    typedef struct packed {
        logic [15:0] keys;
        logic [11:0] disp;
        logic [3:0]  tries;
        logic [3:0]  tone;  // 1 when the key is accepted and clicks
    } step_t;

    localparam int NUM_STEPS = 55;
    localparam int LOCK_ROW  = 53;  // first row after the countdown
    localparam int IDLE      = 120;
    localparam int LIMIT     = 1000;

    // digits 0..9 are 0008 0080 0040 0020 0800 0400 0200 8000 4000 2000
    // enter 0001, set 0010, clear 0100, back 1000
    step_t steps [NUM_STEPS] = '{
        36'h0080_FF1_0_1, 36'h0040_F12_0_1, 36'h0020_123_0_1, 36'h1000_F12_0_1,  // entry, back
        36'h0020_123_0_1, 36'h0800_123_0_1, 36'h0100_FFF_0_1, 36'h0040_FF2_0_1,  // 4th digit dropped
        36'h0800_F24_0_1, 36'h0200_246_0_1, 36'h0001_BCC_0_1, 36'h0400_BCC_0_0,  // pass
        36'h0100_FFF_0_1, 36'h0080_FF1_0_1, 36'h0080_F11_0_1, 36'h0080_111_0_1,
        36'h0001_FFF_1_1, 36'h0400_FF5_1_1, 36'h0001_FF5_1_0, 36'h0400_F55_1_1,  // partial enter
        36'h0400_555_1_1, 36'h0001_FFF_2_1, 36'h2000_FF9_2_1, 36'h2000_F99_2_1,
        36'h2000_999_2_1, 36'h0001_FFF_3_1, 36'h0100_FFF_0_1, 36'h0010_DDD_0_1,  // set mode
        36'h8000_FF7_0_1, 36'h4000_F78_0_1, 36'h2000_789_0_1, 36'h0001_FFF_0_1,
        36'h8000_FF7_0_1, 36'h4000_F78_0_1, 36'h2000_789_0_1, 36'h0001_BCC_0_1,  // new code
        36'h0100_FFF_0_1, 36'h0040_FF2_0_1, 36'h0800_F24_0_1, 36'h0200_246_0_1,
        36'h0001_FFF_1_1, 36'h0040_FF2_1_1, 36'h0800_F24_1_1, 36'h0200_246_1_1,  // old code fails
        36'h0001_FFF_2_1, 36'h0040_FF2_2_1, 36'h0800_F24_2_1, 36'h0200_246_2_1,
        36'h0001_FFF_3_1, 36'h0040_FF2_3_1, 36'h0800_F24_3_1, 36'h0200_246_3_1,
        36'h0001_020_0_1, 36'h0080_000_0_0, 36'h0100_FFF_0_1                     // lockout
    };

    logic        clk;
    logic        rst_n;
    logic [15:0] keys;
    logic [11:0] display;
    logic [3:0]  tries;
    logic        buzzer;
    logic [11:0] prev;
    int          errors;
    int          n;

    code_lock_top #(
        .TICK_DIV  (20),
        .MAX_FAILS (4),
        .TONE_HALF ({32'd5, 32'd3, 32'd2}),  // fail, success, click
        .TONE_LEN  ({32'd90, 32'd60, 32'd30})
    ) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .keys    (keys),
        .display (display),
        .tries   (tries),
        .buzzer  (buzzer)
    );

    always #4 clk = ~clk;

    // bcd minus one via binary
    function automatic logic [11:0] bcd_minus_one(input logic [11:0] v);
        int b;
        b = v[11:8] * 100 + v[7:4] * 10 + v[3:0] - 1;
        return {4'(b / 100), 4'((b / 10) % 10), 4'(b % 10)};
    endfunction

    // press, check two cycles after the event, release and let the tones run out
    task automatic run_step(input step_t s);
        int   t;
        int   edges;
        logic last;
        @(posedge clk);
        keys <= s.keys;
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (display !== s.disp) begin
            errors++;
            $display("mismatch at %0t ns display %h expected %h", $time, display, s.disp);
        end
        if (tries !== s.tries) begin
            errors++;
            $display("mismatch at %0t ns tries %0d expected %0d", $time, tries, s.tries);
        end
        @(posedge clk);
        keys <= '0;
        t = 0;
        while (s.tone != 0 && buzzer !== 1'b1 && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        edges = 0;
        last  = 1'b0;
        repeat (IDLE) begin  // a tone rises, falls and rises again
            @(negedge clk);
            edges += (buzzer !== last);
            last  = buzzer;
        end
        if (t >= LIMIT || (s.tone != 0 && edges < 3) || (s.tone == 0 && edges != 0) ||
            buzzer !== 1'b0) begin
            errors++;
            $display("buzzer did not toggle and fall silent as expected after key %h at %0t ns",
                     s.keys, $time);
        end
    endtask

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        keys   = '0;
        errors = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (display !== 12'hFFF || tries !== 4'd0 || buzzer !== 1'b0) begin
            errors++;
            $display("mismatch at %0t ns reset display %h tries %0d buzzer %b expected FFF 0 0",
                     $time, display, tries, buzzer);
        end
        for (int i = 0; i < LOCK_ROW; i++) begin
            run_step(steps[i]);
        end
        prev = display;
        n    = 0;
        while (display !== 12'h000 && n < LIMIT) begin
            @(posedge clk);
            keys <= (n % 40 == 5) ? 16'h0080 : ((n % 40 == 25) ? 16'h0001 : 16'h0000);
            @(negedge clk);
            if (display !== prev && display !== bcd_minus_one(prev)) begin
                errors++;
                $display("mismatch at %0t ns display %h expected %h", $time, display,
                         bcd_minus_one(prev));
            end
            if (tries !== 4'd0 || buzzer !== 1'b0) begin
                errors++;
                $display("a key during lockout was not ignored at %0t ns", $time);
            end
            prev = display;
            n++;
        end
        @(posedge clk);
        keys <= '0;
        if (n >= LIMIT) begin
            errors++;
            $display("lockout countdown did not reach 000 in time");
        end
        for (int i = LOCK_ROW; i < NUM_STEPS; i++) begin
            run_step(steps[i]);
        end
        n = 0;
        repeat (150) begin  // no key in this window
            @(negedge clk);
            n += buzzer;
        end
        if (n != 0) begin
            errors++;
            $display("buzzer sounded while no key was pressed");
        end
        $display("%0d errors", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
lock_pkg.sv
key_decoder.sv
digit_entry.sv
lock_fsm.sv
tone_gen.sv
buzzer_arbiter.sv
code_lock_top.sv
tb_code_lock.sv
